// File: logic/tilePkg.sv
package tilePkg;

   // ============================================================
   // widths and sizes
   // ============================================================
   localparam int DataW        = 32;               // fabric data word
   localparam int AddrW        = 16;               // fabric address
   localparam int TileIdW      = 4;                // tile id in the fabric
   localparam int MulNum       = 8;                // multiplier slots
   localparam int ScratchDepth = 64;               // scratch words
   localparam int FifoDepth    = 4;                // request buffer entries

   // derived index widths
   localparam int SlotW     = $clog2(MulNum);       // slot number
   localparam int ScratchAw = $clog2(ScratchDepth); // scratch word index
   localparam int FifoPtrW  = $clog2(FifoDepth);    // fifo pointer

   // ============================================================
   // encodings
   // ============================================================
   // transaction kind carried on the fabric
   typedef enum logic [1:0] {
      OpWrite   = 2'd0,                         // store to scratch or cr
      OpRead    = 2'd1,                         // load, answered by a rsp
      OpReadRsp = 2'd2                          // read data going back
   } tFabOpcode;

   // multiplier register field, address bits 1:0
   typedef enum logic [1:0] {
      FieldA      = 2'd0,                       // operand a
      FieldB      = 2'd1,                       // operand b, write starts mul
      FieldResult = 2'd2                        // low word of product
   } tCrField;

endpackage

// File: logic/fabricIngress.sv
module fabricIngress
   import tilePkg::*;
(
   input  logic               Clock,
   input  logic               rstN,
   input  logic [TileIdW-1:0] localTileId,
   input  logic               inValid,
   input  tFabOpcode          inOpcode,
   input  logic [TileIdW-1:0] inTileId,
   input  logic [TileIdW-1:0] inSrcTileId,
   input  logic [AddrW-1:0]   inAddress,
   input  logic [DataW-1:0]   inData,
   input  logic               full,
   output logic               inReady,
   output logic               push,
   output tFabOpcode          reqOpcode,
   output logic [TileIdW-1:0] reqSrcTileId,
   output logic [AddrW-1:0]   reqAddress,
   output logic [DataW-1:0]   reqData
);

   logic regValid;                              // input stage holds a request
   logic keep;                                  // transaction is for this tile

   // only writes and reads addressed to us go on
   assign keep = (inTileId == localTileId) &&
                 ((inOpcode == OpWrite) || (inOpcode == OpRead));

   assign inReady = !regValid || !full;          // stage empty or draining now
   assign push    = regValid && !full;           // move stage into fifo

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         regValid     <= 1'b0;
         reqOpcode    <= OpWrite;
         reqSrcTileId <= '0;
         reqAddress   <= '0;
         reqData      <= '0;
      end else if (inReady) begin
         regValid <= inValid && keep;            // foreign tile or rsp is dropped
         if (inValid && keep) begin
            reqOpcode    <= inOpcode;
            reqSrcTileId <= inSrcTileId;          // becomes rsp destination
            reqAddress   <= inAddress;
            reqData      <= inData;
         end
      end
   end

   // sender keeps a stalled transaction on the bus
   inHeld: assert property (@(posedge Clock) disable iff (!rstN)
      (inValid && !inReady) |=> (inValid && $stable(inOpcode) && $stable(inTileId) &&
                                 $stable(inSrcTileId) && $stable(inAddress) &&
                                 $stable(inData)));

endmodule

// File: logic/reqFifo.sv
module reqFifo
   import tilePkg::*;
(
   input  logic               Clock,
   input  logic               rstN,
   input  logic               push,
   input  tFabOpcode          wrOpcode,
   input  logic [TileIdW-1:0] wrSrcTileId,
   input  logic [AddrW-1:0]   wrAddress,
   input  logic [DataW-1:0]   wrData,
   input  logic               pop,
   output logic               full,
   output logic               empty,
   output tFabOpcode          headOpcode,
   output logic [TileIdW-1:0] headSrcTileId,
   output logic [AddrW-1:0]   headAddress,
   output logic [DataW-1:0]   headData
);

   tFabOpcode          opcodeMem [FifoDepth];
   logic [TileIdW-1:0] srcMem    [FifoDepth];
   logic [AddrW-1:0]   addrMem   [FifoDepth];
   logic [DataW-1:0]   dataMem   [FifoDepth];
   logic [FifoPtrW-1:0] wrPtr;                   // next free entry
   logic [FifoPtrW-1:0] rdPtr;                   // oldest entry
   logic [FifoPtrW:0]   count;                   // entries in use

   assign full  = (count == (FifoPtrW+1)'(FifoDepth));
   assign empty = (count == '0);

   // head is read straight from storage
   assign headOpcode    = opcodeMem[rdPtr];
   assign headSrcTileId = srcMem[rdPtr];
   assign headAddress   = addrMem[rdPtr];
   assign headData      = dataMem[rdPtr];

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
         for (int i = 0; i < FifoDepth; i++) begin
            opcodeMem[i] <= OpWrite;
            srcMem[i]    <= '0;
            addrMem[i]   <= '0;
            dataMem[i]   <= '0;
         end
      end else begin
         if (push) begin
            opcodeMem[wrPtr] <= wrOpcode;
            srcMem[wrPtr]    <= wrSrcTileId;
            addrMem[wrPtr]   <= wrAddress;
            dataMem[wrPtr]   <= wrData;
            wrPtr            <= wrPtr + 1'b1;    // wraps at depth
         end
         if (pop) begin
            rdPtr <= rdPtr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;             // none or both
         endcase
      end
   end

   noPushFull: assert property (@(posedge Clock) disable iff (!rstN)
      push |-> !full);
   noPopEmpty: assert property (@(posedge Clock) disable iff (!rstN)
      pop |-> !empty);

endmodule

// File: logic/accelFarm.sv
module accelFarm
   import tilePkg::*;
(
   input  logic             Clock,
   input  logic             rstN,
   input  logic             mulStart,
   input  logic [SlotW-1:0] mulSlot,
   input  logic [DataW-1:0] mulOpA,
   input  logic [DataW-1:0] mulOpB,
   output logic             mulDone,
   output logic [SlotW-1:0] mulDoneSlot,
   output logic [DataW-1:0] mulProduct
);

   // stage 1 holds operands, stage 2 the product
   logic             s1Valid;
   logic [SlotW-1:0] s1Slot;
   logic [DataW-1:0] s1A;
   logic [DataW-1:0] s1B;
   logic             s2Valid;
   logic [SlotW-1:0] s2Slot;
   logic [DataW-1:0] s2Product;

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         s1Valid   <= 1'b0;
         s1Slot    <= '0;
         s1A       <= '0;
         s1B       <= '0;
         s2Valid   <= 1'b0;
         s2Slot    <= '0;
         s2Product <= '0;
      end else begin
         s1Valid <= mulStart;
         s2Valid <= s1Valid;                     // tag rides with the data
         if (mulStart) begin
            s1Slot <= mulSlot;
            s1A    <= mulOpA;
            s1B    <= mulOpB;
         end
         if (s1Valid) begin
            s2Slot    <= s1Slot;
            s2Product <= s1A * s1B;              // keeps low 32 bits
         end
      end
   end

   assign mulDone     = s2Valid;                 // 2 cycles after start
   assign mulDoneSlot = s2Slot;
   assign mulProduct  = s2Product;

   // a slot owns at most one multiply in the pipe
   noSlotReuse: assert property (@(posedge Clock) disable iff (!rstN)
      mulStart |-> !((s1Valid && (s1Slot == mulSlot)) ||
                     (s2Valid && (s2Slot == mulSlot))));

endmodule

// File: logic/accelMemWrap.sv
module accelMemWrap
   import tilePkg::*;
(
   input  logic               Clock,
   input  logic               rstN,
   input  logic               empty,
   input  tFabOpcode          headOpcode,
   input  logic [TileIdW-1:0] headSrcTileId,
   input  logic [AddrW-1:0]   headAddress,
   input  logic [DataW-1:0]   headData,
   input  logic               fabReady,
   input  logic               mulDone,
   input  logic [SlotW-1:0]   mulDoneSlot,
   input  logic [DataW-1:0]   mulProduct,
   output logic               pop,
   output logic               outValid,
   output logic [TileIdW-1:0] outTileId,
   output logic [AddrW-1:0]   outAddress,
   output logic [DataW-1:0]   outData,
   output logic               mulStart,
   output logic [SlotW-1:0]   mulSlot,
   output logic [DataW-1:0]   mulOpA,
   output logic [DataW-1:0]   mulOpB
);

   typedef enum logic [1:0] {
      WrapIdle,                                 // look at fifo head
      WrapScratchRead,                          // scratch word registered
      WrapWaitBusy,                             // read of slot still multiplying
      WrapRespond                               // rsp on fabric, wait ready
   } tWrapState;

   tWrapState          state;
   logic [DataW-1:0]   scratch [ScratchDepth];
   logic [DataW-1:0]   opA     [MulNum];
   logic [DataW-1:0]   opB     [MulNum];
   logic [DataW-1:0]   result  [MulNum];
   logic [MulNum-1:0]  busy;                    // slot has a mul in flight
   logic [DataW-1:0]   scratchRdData;           // sync read of scratch

   logic               isScratch;
   logic [ScratchAw-1:0] scratchIdx;
   logic [SlotW-1:0]   headSlot;
   tCrField            headField;
   logic               slotBusy;
   logic               headWrite;
   logic [DataW-1:0]   crRdData;
   logic [DataW-1:0]   respData;
   logic               respLoad;

   // ============================================================
   // head decode
   // ============================================================
   assign isScratch  = headAddress[AddrW-1];     // bit 15 picks scratch
   assign scratchIdx = headAddress[ScratchAw-1:0];
   assign headSlot   = headAddress[SlotW+1:2];
   assign headField  = tCrField'(headAddress[1:0]);
   assign slotBusy   = busy[headSlot];
   assign headWrite  = (state == WrapIdle) && !empty && (headOpcode == OpWrite);

   always_comb begin
      case (headField)
         FieldA:      crRdData = opA[headSlot];
         FieldB:      crRdData = opB[headSlot];
         FieldResult: crRdData = result[headSlot];
         default:     crRdData = '0;            // unmapped field reads zero
      endcase
   end

   // b write to a busy slot stalls at the head
   assign mulStart = headWrite && !isScratch && (headField == FieldB) && !slotBusy;
   assign mulSlot  = headSlot;
   assign mulOpA   = opA[headSlot];
   assign mulOpB   = headData;                   // new b goes straight in

   always_comb begin
      pop = 1'b0;
      case (state)
         WrapIdle: begin
            if (!empty) begin
               if (headOpcode == OpRead) begin
                  pop = !isScratch && !slotBusy; // cr read answered at once
               end else begin
                  pop = !(headWrite && !isScratch && (headField == FieldB) && slotBusy);
               end
            end
         end
         WrapScratchRead: pop = 1'b1;
         WrapWaitBusy:    pop = !slotBusy;       // done cleared busy
         default:         pop = 1'b0;            // hold while rsp pending
      endcase
   end

   assign respLoad = pop && (headOpcode == OpRead);
   assign respData = (state == WrapScratchRead) ? scratchRdData : crRdData;

   // ============================================================
   // fsm and response register
   // ============================================================
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         state         <= WrapIdle;
         scratchRdData <= '0;
         outValid      <= 1'b0;
         outTileId     <= '0;
         outAddress    <= '0;
         outData       <= '0;
      end else begin
         case (state)
            WrapIdle: begin
               if (!empty && (headOpcode == OpRead)) begin
                  if (isScratch) begin
                     scratchRdData <= scratch[scratchIdx];
                     state         <= WrapScratchRead;
                  end else if (slotBusy) begin
                     state <= WrapWaitBusy;
                  end else begin
                     state <= WrapRespond;
                  end
               end
            end
            WrapScratchRead: state <= WrapRespond;
            WrapWaitBusy:    if (!slotBusy) state <= WrapRespond;
            WrapRespond:     if (fabReady) state <= WrapIdle;
            default:         state <= WrapIdle;
         endcase
         if (respLoad) begin
            outValid   <= 1'b1;
            outTileId  <= headSrcTileId;         // back to the requester
            outAddress <= headAddress;
            outData    <= respData;
         end else if (outValid && fabReady) begin
            outValid <= 1'b0;
         end
      end
   end

   // ============================================================
   // scratch memory and multiplier registers
   // ============================================================
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         busy <= '0;
         for (int i = 0; i < ScratchDepth; i++) begin
            scratch[i] <= '0;
         end
         for (int s = 0; s < MulNum; s++) begin
            opA[s]    <= '0;
            opB[s]    <= '0;
            result[s] <= '0;
         end
      end else begin
         if (headWrite && isScratch) begin
            scratch[scratchIdx] <= headData;
         end
         if (headWrite && !isScratch && (headField == FieldA)) begin
            opA[headSlot] <= headData;
         end
         if (mulStart) begin
            opB[headSlot]  <= headData;
            busy[headSlot] <= 1'b1;
         end
         if (mulDone) begin
            result[mulDoneSlot] <= mulProduct;   // low word only
            busy[mulDoneSlot]   <= 1'b0;
         end
      end
   end

   // rsp held until the fabric takes it
   rspStable: assert property (@(posedge Clock) disable iff (!rstN)
      (outValid && !fabReady) |=> (outValid && $stable(outTileId) &&
                                   $stable(outAddress) && $stable(outData)));

endmodule

// File: logic/accelTile.sv
module accelTile
   import tilePkg::*;
(
   input  logic               Clock,
   input  logic               rstN,
   input  logic [TileIdW-1:0] localTileId,
   // ============================================================
   // fabric in
   // ============================================================
   input  logic               inValid,
   input  tFabOpcode          inOpcode,
   input  logic [TileIdW-1:0] inTileId,
   input  logic [TileIdW-1:0] inSrcTileId,
   input  logic [AddrW-1:0]   inAddress,
   input  logic [DataW-1:0]   inData,
   output logic               inReady,
   // ============================================================
   // fabric out, read responses only
   // ============================================================
   output logic               outValid,
   output logic [TileIdW-1:0] outTileId,
   output logic [AddrW-1:0]   outAddress,
   output logic [DataW-1:0]   outData,
   input  logic               fabReady
);

   // ingress to buffer
   logic               push;
   logic               full;
   tFabOpcode          reqOpcode;
   logic [TileIdW-1:0] reqSrcTileId;
   logic [AddrW-1:0]   reqAddress;
   logic [DataW-1:0]   reqData;
   // buffer to wrapper
   logic               pop;
   logic               empty;
   tFabOpcode          headOpcode;
   logic [TileIdW-1:0] headSrcTileId;
   logic [AddrW-1:0]   headAddress;
   logic [DataW-1:0]   headData;
   // wrapper to farm and back
   logic               mulStart;
   logic [SlotW-1:0]   mulSlot;
   logic [DataW-1:0]   mulOpA;
   logic [DataW-1:0]   mulOpB;
   logic               mulDone;
   logic [SlotW-1:0]   mulDoneSlot;
   logic [DataW-1:0]   mulProduct;

   fabricIngress fabricIngress_i (
      .Clock        (Clock),
      .rstN         (rstN),
      .localTileId  (localTileId),
      .inValid      (inValid),
      .inOpcode     (inOpcode),
      .inTileId     (inTileId),
      .inSrcTileId  (inSrcTileId),
      .inAddress    (inAddress),
      .inData       (inData),
      .full         (full),
      .inReady      (inReady),
      .push         (push),
      .reqOpcode    (reqOpcode),
      .reqSrcTileId (reqSrcTileId),
      .reqAddress   (reqAddress),
      .reqData      (reqData)
   );

   reqFifo reqFifo_i (
      .Clock         (Clock),
      .rstN          (rstN),
      .push          (push),
      .wrOpcode      (reqOpcode),
      .wrSrcTileId   (reqSrcTileId),
      .wrAddress     (reqAddress),
      .wrData        (reqData),
      .pop           (pop),
      .full          (full),
      .empty         (empty),
      .headOpcode    (headOpcode),
      .headSrcTileId (headSrcTileId),
      .headAddress   (headAddress),
      .headData      (headData)
   );

   accelMemWrap accelMemWrap_i (
      .Clock         (Clock),
      .rstN          (rstN),
      .empty         (empty),
      .headOpcode    (headOpcode),
      .headSrcTileId (headSrcTileId),
      .headAddress   (headAddress),
      .headData      (headData),
      .fabReady      (fabReady),
      .mulDone       (mulDone),
      .mulDoneSlot   (mulDoneSlot),
      .mulProduct    (mulProduct),
      .pop           (pop),
      .outValid      (outValid),
      .outTileId     (outTileId),
      .outAddress    (outAddress),
      .outData       (outData),
      .mulStart      (mulStart),
      .mulSlot       (mulSlot),
      .mulOpA        (mulOpA),
      .mulOpB        (mulOpB)
   );

   accelFarm accelFarm_i (
      .Clock       (Clock),
      .rstN        (rstN),
      .mulStart    (mulStart),
      .mulSlot     (mulSlot),
      .mulOpA      (mulOpA),
      .mulOpB      (mulOpB),
      .mulDone     (mulDone),
      .mulDoneSlot (mulDoneSlot),
      .mulProduct  (mulProduct)
   );

endmodule

// File: testbench/tbClock.sv
module tbClock (
   output logic Clock,
   output logic rstN
);

   localparam int HalfPeriod  = 10;             // period 20
   localparam int ResetCycles = 3;

   initial begin
      Clock = 1'b0;
      forever #(HalfPeriod) Clock = ~Clock;
   end

   initial begin
      rstN <= 1'b0;                             // asserted from time 0
      repeat (ResetCycles) @(posedge Clock);
      rstN <= 1'b1;                             // released on a rising edge
   end

endmodule

// File: testbench/accelTileTb.sv
module accelTileTb
   import tilePkg::*;
();

   localparam int Cols     = 7;                 // values per pattern line
   localparam int MaxLines = 96;
   localparam int Timeout  = 1000;              // cycles per wait
   localparam logic [TileIdW-1:0] MyTile = 4'h3;
   localparam logic [31:0] Seed = 32'hd9979765;
   // pattern columns
   localparam int ColTest = 0;
   localparam int ColOp   = 1;
   localparam int ColDst  = 2;
   localparam int ColSrc  = 3;
   localparam int ColAddr = 4;
   localparam int ColData = 5;
   localparam int ColExp  = 6;

   logic               Clock;
   logic               rstN;
   logic [TileIdW-1:0] localTileId;
   logic               inValid;
   tFabOpcode          inOpcode;
   logic [TileIdW-1:0] inTileId;
   logic [TileIdW-1:0] inSrcTileId;
   logic [AddrW-1:0]   inAddress;
   logic [DataW-1:0]   inData;
   logic               inReady;
   logic               outValid;
   logic [TileIdW-1:0] outTileId;
   logic [AddrW-1:0]   outAddress;
   logic [DataW-1:0]   outData;
   logic               fabReady;

   logic [31:0]        patMem [MaxLines*Cols];
   logic [TileIdW-1:0] expTile [$];             // filled when a read is sent
   logic [AddrW-1:0]   expAddr [$];
   logic [DataW-1:0]   expData [$];
   logic [TileIdW-1:0] rspTile [$];             // filled by the monitor
   logic [AddrW-1:0]   rspAddr [$];
   logic [DataW-1:0]   rspData [$];
   logic [31:0]        lcgState;
   logic               readSent  = 1'b0;
   logic               timedOut  = 1'b0;        // a wait ran out
   int                 curTest   = 0;
   int                 startErrs = 0;
   int                 errors    = 0;
   int                 monErrors = 0;           // owned by the monitor
   int                 checks    = 0;
   int                 testsRun  = 0;
   int                 testsBad  = 0;
   int                 expCount  = 0;
   int                 rspCount  = 0;

   tbClock tbClock_i (
      .Clock (Clock),
      .rstN  (rstN)
   );

   accelTile accelTile_i (
      .Clock       (Clock),
      .rstN        (rstN),
      .localTileId (localTileId),
      .inValid     (inValid),
      .inOpcode    (inOpcode),
      .inTileId    (inTileId),
      .inSrcTileId (inSrcTileId),
      .inAddress   (inAddress),
      .inData      (inData),
      .inReady     (inReady),
      .outValid    (outValid),
      .outTileId   (outTileId),
      .outAddress  (outAddress),
      .outData     (outData),
      .fabReady    (fabReady)
   );

   // ============================================================
   // helpers
   // ============================================================
   function automatic logic [31:0] lcgNext(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;  // numerical recipes constants
   endfunction

   task automatic reportTimeout(input string what);
      $display("timeout: %s in test %0d", what, curTest);
      timedOut = 1'b1;
   endtask

   task automatic checkField(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      checks++;
      assert (got == exp) else begin
         $display("FAILED %s got %h expected %h in test %0d", name, got, exp, curTest);
         errors++;
      end
   endtask

   task automatic waitForReset();
      int waited;
      waited = 0;
      while ((rstN !== 1'b1) && (waited < Timeout)) begin
         @(posedge Clock);
         waited++;
      end
      if (rstN !== 1'b1) begin
         reportTimeout("reset never released");
      end
   endtask

   // drive one pattern line and hold it until the tile takes it
   task automatic sendTxn(input int line);
      int                 base;
      int                 waited;
      tFabOpcode          op;
      logic [TileIdW-1:0] dst;
      base   = line * Cols;
      waited = 0;
      op     = tFabOpcode'(patMem[base+ColOp][1:0]);
      dst    = patMem[base+ColDst][TileIdW-1:0];
      if ((op == OpRead) && (dst == MyTile)) begin          // only these answer
         expTile.push_back(patMem[base+ColSrc][TileIdW-1:0]); // rsp goes to sender
         expAddr.push_back(patMem[base+ColAddr][AddrW-1:0]);
         expData.push_back(patMem[base+ColExp]);
         expCount++;
         readSent = 1'b1;
      end
      inValid     <= 1'b1;
      inOpcode    <= op;
      inTileId    <= dst;
      inSrcTileId <= patMem[base+ColSrc][TileIdW-1:0];
      inAddress   <= patMem[base+ColAddr][AddrW-1:0];
      inData      <= patMem[base+ColData];
      @(posedge Clock);
      while (!inReady && (waited < Timeout)) begin
         @(posedge Clock);
         waited++;
      end
      if (!inReady) begin
         reportTimeout("fabric input never became ready");
      end
   endtask

   // drain the responses of one test and compare them in order
   task automatic finishTest();
      int                 waited;
      int                 testErrs;
      logic [TileIdW-1:0] gotTile;
      logic [TileIdW-1:0] wantTile;
      logic [AddrW-1:0]   gotAddr;
      logic [AddrW-1:0]   wantAddr;
      waited  = 0;
      inValid <= 1'b0;
      while ((rspData.size() < expData.size()) && (waited < Timeout)) begin
         @(posedge Clock);
         waited++;
      end
      if (rspData.size() < expData.size()) begin
         reportTimeout("read responses missing");
         return;
      end
      while ((expData.size() > 0) && (rspData.size() > 0)) begin
         gotTile  = rspTile.pop_front();
         wantTile = expTile.pop_front();
         gotAddr  = rspAddr.pop_front();
         wantAddr = expAddr.pop_front();
         checkField("outTileId", 32'(gotTile), 32'(wantTile));
         checkField("outAddress", 32'(gotAddr), 32'(wantAddr));
         checkField("outData", rspData.pop_front(), expData.pop_front());
      end
      assert (rspData.size() == 0) else begin
         $display("a read response came back for no read in test %0d", curTest);
         errors++;
      end
      testErrs = errors + monErrors - startErrs;
      testsRun++;
      if (testErrs != 0) begin
         testsBad++;
      end
      $display("test %0d: %0d errors, %s", curTest, testErrs, (testErrs == 0) ? "ok" : "bad");
   endtask

   // ============================================================
   // fabric back-pressure and response monitor
   // ============================================================
   initial begin
      lcgState = Seed;
      fabReady <= 1'b0;
      forever begin
         @(posedge Clock);
         lcgState = lcgNext(lcgState);
         fabReady <= lcgState[31];               // ready about half the time
      end
   end

   initial begin
      @(posedge Clock);                          // first edge applies reset
      forever begin
         @(posedge Clock);
         if (!readSent) begin
            assert (outValid == 1'b0) else begin
               $display("FAILED outValid got %h expected %h before any read", outValid, 1'b0);
               monErrors++;
            end
         end
         if (rstN && outValid && fabReady) begin
            rspTile.push_back(outTileId);
            rspAddr.push_back(outAddress);
            rspData.push_back(outData);
            rspCount++;
         end
      end
   end

   // ============================================================
   // stimulus from the pattern file
   // ============================================================
   initial begin
      int line;
      int num;
      localTileId <= MyTile;
      inValid     <= 1'b0;
      inOpcode    <= OpWrite;
      inTileId    <= '0;
      inSrcTileId <= '0;
      inAddress   <= '0;
      inData      <= '0;
      $readmemh("testbench/accelTilePatterns.hex", patMem);
      waitForReset();
      line = 0;
      while (!timedOut && (line < MaxLines) &&
             (patMem[line*Cols+ColTest] != 32'd0)) begin // 0 ends
         num = int'(patMem[line*Cols+ColTest]);
         if (num != curTest) begin
            if (curTest != 0) begin
               finishTest();
            end
            curTest   = num;
            startErrs = errors + monErrors;
         end
         if (!timedOut) begin
            sendTxn(line);
         end
         line++;
      end
      if ((curTest != 0) && !timedOut) begin
         finishTest();
      end
      if (!timedOut) begin
         checkField("response count", 32'(rspCount), 32'(expCount));
      end
      $display("summary: %0d tests run, %0d with errors, %0d checks, %0d errors",
               testsRun, testsBad, checks, errors + monErrors);
      if (((errors + monErrors) == 0) && !timedOut) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// File: testbench/accelTilePatterns.hex
// test op dst src addr data expect, one transaction per line, test 0 ends the list
// op 0 write, 1 read, 2 read response; expect is outData of a read to tile 3
6 1 3 1 0002 00000000 00000000  // slot 0 result before any mul
6 1 3 2 001e 00000000 00000000
6 1 3 5 0004 00000000 00000000  // slot 1 operand a
6 1 3 6 8000 00000000 00000000
1 0 3 1 8000 a5a5a5a5 00000000
1 0 3 1 8001 12345678 00000000
1 0 3 1 803f deadbeef 00000000  // top word
1 0 3 1 8001 0badf00d 00000000  // overwrite word 1
1 1 3 1 8000 00000000 a5a5a5a5
1 1 3 2 8001 00000000 0badf00d
1 1 3 3 803f 00000000 deadbeef
1 1 3 4 8010 00000000 00000000  // never written
2 0 3 1 0000 00000003 00000000  // slot 0
2 0 3 1 0001 00000005 00000000
2 0 3 1 0008 ffffffff 00000000  // slot 2 all ones
2 0 3 1 0009 ffffffff 00000000
2 0 3 1 0014 12345678 00000000  // slot 5
2 0 3 1 0015 00000010 00000000
2 0 3 1 001c ffffffff 00000000  // slot 7
2 0 3 1 001d 00000002 00000000
2 1 3 2 0002 00000000 0000000f
2 1 3 2 000a 00000000 00000001
2 1 3 2 0016 00000000 23456780
2 1 3 2 001e 00000000 fffffffe
2 1 3 2 0008 00000000 ffffffff  // operand a reads back
3 0 3 4 0000 00000007 00000000
3 0 3 4 0001 00000006 00000000
3 1 3 4 0002 00000000 0000002a  // right behind the b write
3 0 3 4 0001 00000010 00000000
3 1 3 4 0002 00000000 00000070
3 0 3 4 0001 00000002 00000000
3 0 3 4 0001 00000003 00000000  // b while slot busy
3 1 3 4 0002 00000000 00000015
3 1 3 4 0001 00000000 00000003
4 0 5 1 8020 11111111 00000000  // other tile
4 2 3 1 8021 22222222 00000000  // rsp opcode
4 1 5 1 8000 00000000 00000000
4 2 3 1 8000 00000000 00000000
4 0 a 1 0004 99999999 00000000
4 0 a 1 0005 00000002 00000000  // would start slot 1
4 0 3 1 0006 55555555 00000000  // result not writable
4 1 3 2 8020 00000000 00000000
4 1 3 2 8021 00000000 00000000
4 1 3 2 0004 00000000 00000000
4 1 3 2 0006 00000000 00000000
5 1 3 1 8000 00000000 a5a5a5a5
5 1 3 6 8001 00000000 0badf00d
5 1 3 7 803f 00000000 deadbeef
5 0 3 8 8005 cafef00d 00000000
5 1 3 8 8005 00000000 cafef00d
5 1 3 9 000a 00000000 00000001
5 1 3 a 0016 00000000 23456780
5 1 3 b 001e 00000000 fffffffe
5 1 3 c 0002 00000000 00000015
5 1 3 d 0009 00000000 ffffffff
5 1 3 e 8010 00000000 00000000
5 1 3 f 0014 00000000 12345678
0 0 0 0 0000 00000000 00000000  // end of list

// File: verilog.f
logic/tilePkg.sv
logic/fabricIngress.sv
logic/reqFifo.sv
logic/accelFarm.sv
logic/accelMemWrap.sv
logic/accelTile.sv
testbench/tbClock.sv
testbench/accelTileTb.sv

// File: Makefile
TOP := accelTileTb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

obj_dir/V$(TOP): verilog.f logic/*.sv testbench/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "tests failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
